// File: design/pkt_buffer_top.sv
`timescale 1ns/1ps

module pkt_buffer_top #(
	parameter int DATA_WIDTH = pkt_pkg::DEFAULT_DATA_WIDTH,
	parameter int ADDR_WIDTH = pkt_pkg::DEFAULT_ADDR_WIDTH,
	parameter bit READY_REG  = 1'b1
) (
	input  logic                  clk,
	input  logic                  arst_n,
	// Ingest side, plain strobes with a ready level
	input  logic [DATA_WIDTH-1:0] in_data,
	input  logic                  in_valid,
	input  logic                  in_last,
	output logic                  in_ready,
	// Output stream, valid/ready
	output logic [DATA_WIDTH-1:0] out_data,
	output logic                  out_valid,
	output logic                  out_last,
	input  logic                  out_ready
);

	// Ingest to memory
	logic                  wr_en;
	logic [ADDR_WIDTH-1:0] wr_addr;
	logic [DATA_WIDTH-1:0] wr_data;
	logic                  commit;
	logic [ADDR_WIDTH-1:0] commit_last_addr;
	logic                  slot_free;

	// Memory to forwarder
	logic                  slot_full;
	logic [ADDR_WIDTH-1:0] slot_last_addr;
	logic                  rd_en;
	logic [ADDR_WIDTH-1:0] rd_addr;
	logic [DATA_WIDTH-1:0] rd_data;
	logic                  done;

	pkt_ingest #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH)
	) ingest_i (
		.clk              (clk),
		.arst_n           (arst_n),
		.in_data          (in_data),
		.in_valid         (in_valid),
		.in_last          (in_last),
		.in_ready         (in_ready),
		.slot_free        (slot_free),
		.wr_en            (wr_en),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.commit           (commit),
		.commit_last_addr (commit_last_addr)
	);

	pkt_mem #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH)
	) mem_i (
		.clk              (clk),
		.arst_n           (arst_n),
		.wr_en            (wr_en),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.commit           (commit),
		.commit_last_addr (commit_last_addr),
		.rd_en            (rd_en),
		.rd_addr          (rd_addr),
		.rd_data          (rd_data),
		.done             (done),
		.slot_free        (slot_free),
		.slot_full        (slot_full),
		.slot_last_addr   (slot_last_addr)
	);

	pkt_forwarder #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH),
		.READY_REG (READY_REG)
	) forwarder_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.slot_full      (slot_full),
		.slot_last_addr (slot_last_addr),
		.rd_en          (rd_en),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.done           (done),
		.out_data       (out_data),
		.out_valid      (out_valid),
		.out_last       (out_last),
		.out_ready      (out_ready)
	);

endmodule

// File: design/pkt_forwarder.sv
`timescale 1ns/1ps

module pkt_forwarder #(
	parameter int DATA_WIDTH = pkt_pkg::DEFAULT_DATA_WIDTH,
	parameter int ADDR_WIDTH = pkt_pkg::DEFAULT_ADDR_WIDTH,
	parameter bit READY_REG  = 1'b0
) (
	input  logic                  clk,
	input  logic                  arst_n,
	// Slot state from the memory
	input  logic                  slot_full,
	input  logic [ADDR_WIDTH-1:0] slot_last_addr,
	// Read port of the memory
	output logic                  rd_en,
	output logic [ADDR_WIDTH-1:0] rd_addr,
	input  logic [DATA_WIDTH-1:0] rd_data,
	// Frees the slot, high for exactly one cycle
	output logic                  done,
	// Output stream
	output logic [DATA_WIDTH-1:0] out_data,
	output logic                  out_valid,
	output logic                  out_last,
	input  logic                  out_ready
);

	logic slot_ready;

	////////////////////////////////////////////////////////////
	// Slot ready, optionally registered
	////////////////////////////////////////////////////////////

	generate
		if (READY_REG) begin : gen_ready_reg
			logic slot_ready_q;

			// Breaks the path from slot_full into rd_en
			// The flag lags by a cycle, so it is dropped on done to avoid
			// starting a read on a slot that is being released
			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n)
					slot_ready_q <= 1'b0;
				else
					slot_ready_q <= slot_full && !done;
			end

			assign slot_ready = slot_ready_q;
		end else begin : gen_ready_comb
			assign slot_ready = slot_full;
		end
	endgenerate

	////////////////////////////////////////////////////////////
	// Read control and output register
	////////////////////////////////////////////////////////////

	// The memory output register doubles as the stream register
	assign out_data = rd_data;

	// Read when the slot is ready and the output is empty or being taken
	// Once the last word is out nothing more is fetched for this packet
	assign rd_en = slot_ready && (out_ready || !out_valid) && !out_last;

	// Last beat leaving the output frees the slot
	assign done = out_valid && out_ready && out_last;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_addr   <= '0;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			// Valid stays up while a held beat waits, or a new word arrives
			out_valid <= rd_en || (out_valid && !out_ready);
			if (rd_en) begin
				// Wrap to zero so the next packet starts at the base
				if (rd_addr == slot_last_addr)
					rd_addr <= '0;
				else
					rd_addr <= rd_addr + 1'b1;
				out_last <= (rd_addr == slot_last_addr);
			end else if (out_valid && out_ready) begin
				out_last <= 1'b0;
			end
		end
	end

endmodule

// File: design/pkt_ingest.sv
`timescale 1ns/1ps

module pkt_ingest #(
	parameter int DATA_WIDTH = pkt_pkg::DEFAULT_DATA_WIDTH,
	parameter int ADDR_WIDTH = pkt_pkg::DEFAULT_ADDR_WIDTH
) (
	input  logic                  clk,
	input  logic                  arst_n,
	// Upstream word source
	input  logic [DATA_WIDTH-1:0] in_data,
	input  logic                  in_valid,
	input  logic                  in_last,
	output logic                  in_ready,
	// Slot ownership as seen from the memory
	input  logic                  slot_free,
	// Write port of the packet memory
	output logic                  wr_en,
	output logic [ADDR_WIDTH-1:0] wr_addr,
	output logic [DATA_WIDTH-1:0] wr_data,
	// Length hand-off, commit is a one-cycle pulse
	output logic                  commit,
	output logic [ADDR_WIDTH-1:0] commit_last_addr
);

	// Highest address of the memory, where an overlong packet gets cut
	localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = '1;

	pkt_pkg::ingest_state_t state;
	logic [ADDR_WIDTH-1:0]  wr_ptr;
	logic                   accept;

	// Words are only taken while collecting or discarding and the slot is ours
	assign in_ready = ((state == pkt_pkg::ST_COLLECT) || (state == pkt_pkg::ST_DISCARD))
		&& slot_free;
	assign accept   = in_valid && in_ready;

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= pkt_pkg::ST_COLLECT;
			wr_ptr <= '0;
			wr_en  <= 1'b0;
			commit <= 1'b0;
		end else begin
			// Only words kept in ST_COLLECT reach the memory
			wr_en  <= accept && (state == pkt_pkg::ST_COLLECT);
			commit <= 1'b0;
			case (state)
				pkt_pkg::ST_COLLECT: begin
					if (accept) begin
						if (in_last) begin
							commit <= 1'b1;
							wr_ptr <= '0;
							state  <= pkt_pkg::ST_WAIT_FREE;
						end else if (wr_ptr == LAST_ADDR) begin
							// Memory is full, the pointer stays on the last address
							state <= pkt_pkg::ST_DISCARD;
						end else begin
							wr_ptr <= wr_ptr + 1'b1;
						end
					end
				end
				pkt_pkg::ST_DISCARD: begin
					// The tail is swallowed, the packet ends at the last address
					if (accept && in_last) begin
						commit <= 1'b1;
						wr_ptr <= '0;
						state  <= pkt_pkg::ST_WAIT_FREE;
					end
				end
				pkt_pkg::ST_WAIT_FREE: begin
					// slot_free is still stale while commit is high
					if (slot_free && !commit)
						state <= pkt_pkg::ST_COLLECT;
				end
				default: state <= pkt_pkg::ST_COLLECT;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Write data and length
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept && (state == pkt_pkg::ST_COLLECT)) begin
			wr_addr <= wr_ptr;
			wr_data <= in_data;
		end
		// In ST_DISCARD the pointer already sits on LAST_ADDR
		if (accept && in_last)
			commit_last_addr <= wr_ptr;
	end

endmodule

// File: design/pkt_mem.sv
`timescale 1ns/1ps

module pkt_mem #(
	parameter int DATA_WIDTH = pkt_pkg::DEFAULT_DATA_WIDTH,
	parameter int ADDR_WIDTH = pkt_pkg::DEFAULT_ADDR_WIDTH
) (
	input  logic                  clk,
	input  logic                  arst_n,
	// Write port from ingest
	input  logic                  wr_en,
	input  logic [ADDR_WIDTH-1:0] wr_addr,
	input  logic [DATA_WIDTH-1:0] wr_data,
	// Length commit from ingest
	input  logic                  commit,
	input  logic [ADDR_WIDTH-1:0] commit_last_addr,
	// Read port from the forwarder
	input  logic                  rd_en,
	input  logic [ADDR_WIDTH-1:0] rd_addr,
	output logic [DATA_WIDTH-1:0] rd_data,
	// One-cycle pulse from the forwarder when the last word has left
	input  logic                  done,
	// Slot state
	output logic                  slot_free,
	output logic                  slot_full,
	output logic [ADDR_WIDTH-1:0] slot_last_addr
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] mem [0:DEPTH-1];

	////////////////////////////////////////////////////////////
	// Word storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Registered read, same-address collisions return the old word
	// The output holds while rd_en is low so a stalled beat stays put
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

	////////////////////////////////////////////////////////////
	// Slot ownership
	////////////////////////////////////////////////////////////

	// Full from the edge after commit until the edge after done
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			slot_full <= 1'b0;
		end else begin
			if (commit)
				slot_full <= 1'b1;
			else if (done)
				slot_full <= 1'b0;
		end
	end

	// Address of the final word, loaded together with the full flag
	always_ff @(posedge clk) begin
		if (commit)
			slot_last_addr <= commit_last_addr;
	end

	// Ingest only needs the inverse, so it is provided here once
	assign slot_free = !slot_full;

endmodule

// File: design/pkt_pkg.sv
package pkt_pkg;

	////////////////////////////////////////////////////////////
	// Default widths
	////////////////////////////////////////////////////////////

	// Word width of the datapath in bits
	localparam int DEFAULT_DATA_WIDTH = 32;

	// Address width of the packet memory, so 16 words deep by default
	localparam int DEFAULT_ADDR_WIDTH = 4;

	////////////////////////////////////////////////////////////
	// Ingest FSM encoding
	////////////////////////////////////////////////////////////

	// ST_COLLECT takes words and writes them into the packet memory
	// ST_DISCARD drops the tail of a packet that outgrew the memory
	// ST_WAIT_FREE holds off new words until the forwarder frees the slot
	typedef enum logic [1:0] {
		ST_COLLECT   = 2'd0,
		ST_DISCARD   = 2'd1,
		ST_WAIT_FREE = 2'd2
	} ingest_state_t;

endpackage

// File: pkt_buffer_top.f
design/pkt_pkg.sv
design/pkt_ingest.sv
design/pkt_mem.sv
design/pkt_forwarder.sv
design/pkt_buffer_top.sv
sim/pkt_buffer_properties.sv
sim/pkt_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench twice, once per READY_REG setting
cd "$(dirname "$0")" || exit 1

run_variant() {
	verilator --binary --timing --assert -f pkt_buffer_top.f --top-module pkt_buffer_tb \
		-Mdir "$1" "${@:2}" &&
	"./$1/Vpkt_buffer_tb" | tee /dev/stderr | grep -q "Simulation completed successfully"
}

run_variant obj_ready_reg1 && run_variant obj_ready_reg0 -GREADY_REG=0 &&
	echo "Both READY_REG variants passed" ||
	{ echo "Testbench run failed" >&2; exit 1; }

// File: sim/pkt_buffer_properties.sv
`timescale 1ns/1ps

module pkt_buffer_properties #(
	parameter int DATA_WIDTH = pkt_pkg::DEFAULT_DATA_WIDTH
) (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  in_valid,
	input logic                  in_last,
	input logic                  in_ready,
	input logic [DATA_WIDTH-1:0] out_data,
	input logic                  out_valid,
	input logic                  out_last,
	input logic                  out_ready
);

	// Shadow of the ingest FSM, rebuilt from the top-level ports only
	// ST_DISCARD is not visible from outside, so only two states are used
	pkt_pkg::ingest_state_t phase;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			phase <= pkt_pkg::ST_COLLECT;
		else if (in_valid && in_ready && in_last)
			phase <= pkt_pkg::ST_WAIT_FREE;
		else if (out_valid && out_ready && out_last)
			phase <= pkt_pkg::ST_COLLECT;
	end

	////////////////////////////////////////////////////////////
	// Output stream rules
	////////////////////////////////////////////////////////////

	// A stalled beat must not move or vanish
	stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
		else $error("Stalled output beat changed or dropped valid");

	last_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
		out_last |-> out_valid)
		else $error("out_last high without out_valid");

	// The slot is owned by the forwarder until its final beat has left
	ingest_blocked: assert property (@(posedge clk) disable iff (!arst_n)
		(phase == pkt_pkg::ST_WAIT_FREE) |-> !in_ready)
		else $error("in_ready high while a committed packet is still in the buffer");

endmodule

bind pkt_buffer_top pkt_buffer_properties #(.DATA_WIDTH(DATA_WIDTH)) props_i (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.in_last   (in_last),
	.in_ready  (in_ready),
	.out_data  (out_data),
	.out_valid (out_valid),
	.out_last  (out_last),
	.out_ready (out_ready)
);

// File: sim/pkt_buffer_tb.sv
`timescale 1ns/1ps

module pkt_buffer_tb #(
	parameter bit READY_REG = 1'b1
);

	localparam int DATA_WIDTH = pkt_pkg::DEFAULT_DATA_WIDTH;
	localparam int ADDR_WIDTH = pkt_pkg::DEFAULT_ADDR_WIDTH;
	localparam int DEPTH      = 1 << ADDR_WIDTH;
	// All tests move about 60 words; random stalls double that and each
	// packet adds a few cycles of slot turnaround, so 4000 is ample
	localparam int MAX_CYCLES = 4000;

	logic                  clk = 1'b0;
	logic                  arst_n;
	logic [DATA_WIDTH-1:0] in_data;
	logic                  in_valid;
	logic                  in_last;
	logic                  in_ready;
	logic [DATA_WIDTH-1:0] out_data;
	logic                  out_valid;
	logic                  out_last;
	logic                  out_ready;

	// Scoreboard, one entry per word that must come out
	logic [DATA_WIDTH-1:0] exp_data [$];
	bit                    exp_last [$];

	string cur_test     = "reset";
	bit    random_ready = 1'b0;
	int    beat_errors  = 0;
	int    order_errors = 0;
	int    errs_before  = 0;
	int    pkts_sent    = 0;
	int    pkts_rcvd    = 0;
	int    tests_passed = 0;
	int    tests_failed = 0;
	int    cycle_count;

	pkt_buffer_top #(
		.DATA_WIDTH(DATA_WIDTH),
		.ADDR_WIDTH(ADDR_WIDTH),
		.READY_REG (READY_REG)
	) dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_last   (in_last),
		.in_ready  (in_ready),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_ready (out_ready)
	);

	// 40 ns period
	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Sink side: ready driver and beat checker
	////////////////////////////////////////////////////////////

	// out_ready is either held high or tossed each cycle
	initial begin : ready_driver
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (random_ready)
				out_ready = ($urandom % 2) != 0;
			else
				out_ready = 1'b1;
		end
	end

	// Beats are looked at mid-cycle, where both valid and ready are settled
	initial begin : beat_checker
		logic [DATA_WIDTH-1:0] want_data;
		bit                    want_last;
		forever begin
			@(negedge clk);
			if (arst_n && out_valid && out_ready) begin
				if (exp_data.size() == 0) begin
					$display("Error in %s: output beat %h arrived with no word expected",
						cur_test, out_data);
					beat_errors++;
				end else begin
					want_data = exp_data.pop_front();
					want_last = exp_last.pop_front();
					if (out_data !== want_data) begin
						$display("Fail %s: out_data expected %h actual %h",
							cur_test, want_data, out_data);
						beat_errors++;
					end
					if (out_last !== want_last) begin
						$display("Fail %s: out_last expected %0b actual %0b",
							cur_test, want_last, out_last);
						beat_errors++;
					end
				end
				if (out_last)
					pkts_rcvd++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Source side and test bookkeeping
	////////////////////////////////////////////////////////////

	// Sends len random words; only the first DEPTH survive the truncation
	// rule, and the last survivor is the one that must carry out_last
	task automatic send_packet(input int len);
		int                    idx;
		int                    kept;
		logic [DATA_WIDTH-1:0] word;
		idx  = 0;
		kept = (len > DEPTH) ? DEPTH : len;
		while (idx < len) begin
			if (in_ready) begin
				// The slot must be empty before a new packet may enter
				if (idx == 0 && pkts_rcvd != pkts_sent) begin
					$display("Error in %s: packet %0d accepted before packet %0d left",
						cur_test, pkts_sent + 1, pkts_sent);
					order_errors++;
				end
				word     = $urandom;
				in_valid = 1'b1;
				in_data  = word;
				in_last  = (idx == len - 1);
				if (idx < kept) begin
					exp_data.push_back(word);
					exp_last.push_back(idx == kept - 1);
				end
				idx++;
			end else begin
				in_valid = 1'b0;
				in_last  = 1'b0;
			end
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
		in_last  = 1'b0;
		pkts_sent++;
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		errs_before = beat_errors + order_errors;
	endtask

	// Waits until every expected word has come out, then reports the test
	task automatic finish_test();
		int errs;
		while (exp_data.size() != 0) begin
			@(posedge clk);
			#1;
		end
		errs = beat_errors + order_errors - errs_before;
		if (errs == 0) begin
			$display("Test %s finished with no errors", cur_test);
			tests_passed++;
		end else begin
			$display("Test %s finished with %0d errors", cur_test, errs);
			tests_failed++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic stream_five_words();
		begin_test("five_words");
		send_packet(5);
		finish_test();
	endtask

	task automatic stream_under_backpressure();
		begin_test("random_backpressure");
		random_ready = 1'b1;
		send_packet(12);
		finish_test();
		random_ready = 1'b0;
	endtask

	task automatic stream_single_word();
		begin_test("single_word");
		send_packet(1);
		finish_test();
	endtask

	// Twenty words into sixteen, then a normal packet behind it
	task automatic truncate_overlong();
		begin_test("overlong_truncation");
		send_packet(20);
		send_packet(6);
		finish_test();
	endtask

	task automatic queue_back_to_back();
		begin_test("back_to_back");
		send_packet(4);
		send_packet(9);
		send_packet(3);
		finish_test();
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin : main_sequence
		void'($urandom(32'h1bf5));
		arst_n   = 1'b0;
		in_data  = '0;
		in_valid = 1'b0;
		in_last  = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;
		stream_five_words();
		stream_under_backpressure();
		stream_single_word();
		truncate_overlong();
		queue_back_to_back();
		// A few idle cycles so a stray beat still gets caught
		repeat (10) @(posedge clk);
		$display("Tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, beat_errors + order_errors);
		if (tests_failed == 0 && beat_errors + order_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin : watchdog
		for (cycle_count = 0; cycle_count < MAX_CYCLES; cycle_count++)
			@(posedge clk);
		$display("Error: run did not finish within %0d clock cycles in test %s",
			MAX_CYCLES, cur_test);
		$display("Simulation failed");
		$finish;
	end

endmodule
